// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rob_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_TEXT = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
logic/rob_pkg.sv
logic/rob_alloc_if.sv
logic/rob_cdb_if.sv
logic/rob_pointers.sv
logic/rob_entries.sv
logic/rob_read_port.sv
logic/rob_commit.sv
logic/rob_top.sv
test/rob_checker.sv
test/rob_tb.sv

// File: logic/rob_alloc_if.sv
`timescale 1ns/1ps

interface rob_alloc_if;

    // Requests from the rename stage, one per lane
    logic           enable [rob_pkg::alloc_lanes];
    rob_pkg::tag_t  tag    [rob_pkg::alloc_lanes];
    rob_pkg::dest_t dest   [rob_pkg::alloc_lanes];

    // Answer from the pointer logic
    rob_pkg::slot_t slot   [rob_pkg::alloc_lanes];  // Slot each lane lands in
    logic           grant;                          // All enabled lanes fit

    modport pointers (
        input  enable,
        output slot,
        output grant
    );

    modport entries (
        input enable, tag, dest, slot, grant
    );

    // Read ports only look, for forwarding
    modport reader (
        input enable, tag, dest, slot, grant
    );

endinterface

// File: logic/rob_cdb_if.sv
`timescale 1ns/1ps

interface rob_cdb_if;

    // One-cycle result strobes from the execution units
    logic           valid     [rob_pkg::cdb_lanes];
    rob_pkg::slot_t slot      [rob_pkg::cdb_lanes];
    rob_pkg::data_t data      [rob_pkg::cdb_lanes];
    logic           exception [rob_pkg::cdb_lanes];  // Fault or mispredict

    modport source (
        output valid, slot, data, exception
    );

    modport sink (
        input valid, slot, data, exception
    );

endinterface

// File: logic/rob_commit.sv
`timescale 1ns/1ps

module rob_commit (
    input  rob_pkg::rob_entry_t head_entry       [rob_pkg::commit_lanes],
    input  rob_pkg::count_t     count,
    output logic                commit_valid     [rob_pkg::commit_lanes],
    output rob_pkg::data_t      commit_data      [rob_pkg::commit_lanes],
    output rob_pkg::dest_t      commit_dest      [rob_pkg::commit_lanes],
    output logic                commit_exception [rob_pkg::commit_lanes],
    output rob_pkg::count_t     commit_count
);

    logic older_done;   // This entry and every older one executed

    // In order only, a lane retires when all lanes before it do
    always_comb begin
        older_done   = 1'b1;
        commit_count = '0;
        for (int i = 0; i < rob_pkg::commit_lanes; i++) begin
            older_done          = older_done & head_entry[i].executed;
            commit_valid[i]     = older_done && (count > rob_pkg::count_t'(i));
            commit_count        = commit_count + rob_pkg::count_t'(commit_valid[i]);
            commit_data[i]      = head_entry[i].data;
            commit_dest[i]      = head_entry[i].dest;
            commit_exception[i] = head_entry[i].exception;
        end
    end

endmodule

// File: logic/rob_entries.sv
`timescale 1ns/1ps

module rob_entries (
    input  logic                clk,
    input  logic                reset,
    rob_alloc_if.entries        alloc,
    rob_cdb_if.sink             cdb,
    input  rob_pkg::slot_t      read_slot  [rob_pkg::read_ports],
    output rob_pkg::rob_entry_t read_entry [rob_pkg::read_ports],
    input  rob_pkg::slot_t      head,
    output rob_pkg::rob_entry_t head_entry [rob_pkg::commit_lanes]
);

    rob_pkg::rob_entry_t entries [rob_pkg::rob_depth];

    // ====================
    // Writes
    // ====================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < rob_pkg::rob_depth; i++) begin
                entries[i] <= '0;
            end
        end else begin
            // New entries start waiting on their producer tag
            if (alloc.grant) begin
                for (int i = 0; i < rob_pkg::alloc_lanes; i++) begin
                    if (alloc.enable[i]) begin
                        entries[alloc.slot[i]] <= '{
                            data:      '0,
                            tag:       alloc.tag[i],
                            dest:      alloc.dest[i],
                            executed:  1'b0,
                            exception: 1'b0
                        };
                    end
                end
            end

            // Results come after allocation, so they win on a shared slot.
            // Higher lanes are written last and win among themselves.
            for (int i = 0; i < rob_pkg::cdb_lanes; i++) begin
                if (cdb.valid[i]) begin
                    entries[cdb.slot[i]].data      <= cdb.data[i];
                    entries[cdb.slot[i]].tag       <= rob_pkg::tag_ready;
                    entries[cdb.slot[i]].executed  <= 1'b1;
                    entries[cdb.slot[i]].exception <= cdb.exception[i];
                end
            end
        end
    end

    // ====================
    // Reads
    // ====================
    for (genvar i = 0; i < rob_pkg::read_ports; i++) begin : g_read
        assign read_entry[i] = entries[read_slot[i]];
    end

    // Head and the entries behind it, wrapping round the buffer
    for (genvar i = 0; i < rob_pkg::commit_lanes; i++) begin : g_head
        assign head_entry[i] = entries[rob_pkg::slot_t'(head + i)];
    end

endmodule

// File: logic/rob_pkg.sv
package rob_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int rob_depth    = 8;    // Power of two
    localparam int slot_width   = 3;
    localparam int count_width  = 4;    // Holds 0 to rob_depth
    localparam int data_width   = 32;
    localparam int tag_width    = 3;
    localparam int dest_width   = 5;

    // Lane and port counts
    localparam int alloc_lanes  = 2;
    localparam int cdb_lanes    = 2;
    localparam int read_ports   = 2;
    localparam int commit_lanes = 2;

    // ====================
    // Types
    // ====================
    typedef logic [slot_width-1:0]  slot_t;
    typedef logic [count_width-1:0] count_t;
    typedef logic [data_width-1:0]  data_t;
    typedef logic [tag_width-1:0]   tag_t;
    typedef logic [dest_width-1:0]  dest_t;

    localparam tag_t tag_ready = '1;    // Data is present

    // One buffer entry
    typedef struct packed {
        data_t data;
        tag_t  tag;         // Producer tag until the result arrives
        dest_t dest;        // Architectural destination
        logic  executed;
        logic  exception;
    } rob_entry_t;

endpackage

// File: logic/rob_pointers.sv
`timescale 1ns/1ps

module rob_pointers (
    input  logic            clk,
    input  logic            reset,
    rob_alloc_if.pointers   alloc,
    input  rob_pkg::count_t commit_count,   // 0 to commit_lanes
    output rob_pkg::slot_t  head,
    output rob_pkg::count_t count,
    output logic            empty,
    output logic            full
);

    // Top bit is the wrap flag, it tells full from empty
    logic [rob_pkg::slot_width:0] head_ptr;
    logic [rob_pkg::slot_width:0] tail_ptr;

    rob_pkg::count_t free_slots;
    rob_pkg::count_t requests;      // Enabled lanes this cycle
    rob_pkg::slot_t  lane_offset;

    // ====================
    // Status
    // ====================
    assign count      = rob_pkg::count_t'(tail_ptr - head_ptr);
    assign empty      = (count == '0);
    assign full       = (count == rob_pkg::count_t'(rob_pkg::rob_depth));
    assign free_slots = rob_pkg::count_t'(rob_pkg::rob_depth) - count;
    assign head       = head_ptr[rob_pkg::slot_width-1:0];

    // ====================
    // Allocation
    // ====================

    // Each lane takes the tail plus the enabled lanes below it
    always_comb begin
        requests    = '0;
        lane_offset = '0;
        for (int i = 0; i < rob_pkg::alloc_lanes; i++) begin
            alloc.slot[i] = tail_ptr[rob_pkg::slot_width-1:0] + lane_offset;
            lane_offset   = lane_offset + rob_pkg::slot_t'(alloc.enable[i]);
            requests      = requests + rob_pkg::count_t'(alloc.enable[i]);
        end
    end

    // All requested lanes or none of them
    assign alloc.grant = (free_slots >= requests);

    // ====================
    // Pointer update
    // ====================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + commit_count;    // Oldest entries retire
            if (alloc.grant) begin
                tail_ptr <= tail_ptr + requests;
            end
        end
    end

endmodule

// File: logic/rob_read_port.sv
`timescale 1ns/1ps

module rob_read_port (
    input  rob_pkg::slot_t      read_slot,
    input  rob_pkg::rob_entry_t stored,     // Entry as held in the buffer
    rob_cdb_if.sink             cdb,
    rob_alloc_if.reader         alloc,
    output rob_pkg::data_t      read_data,
    output rob_pkg::tag_t       read_tag
);

    // Priority from lowest to highest. Each match below overrides
    // the ones before it, so the last lane checked wins
    always_comb begin
        read_data = stored.data;
        read_tag  = stored.tag;

        // Entry opened this cycle, result still pending
        if (alloc.grant) begin
            for (int i = 0; i < rob_pkg::alloc_lanes; i++) begin
                if (alloc.enable[i] && (alloc.slot[i] == read_slot)) begin
                    read_data = '0;
                    read_tag  = alloc.tag[i];
                end
            end
        end

        // Result on the bus this cycle
        for (int i = 0; i < rob_pkg::cdb_lanes; i++) begin
            if (cdb.valid[i] && (cdb.slot[i] == read_slot)) begin
                read_data = cdb.data[i];
                read_tag  = rob_pkg::tag_ready;
            end
        end
    end

endmodule

// File: logic/rob_top.sv
`timescale 1ns/1ps

module rob_top (
    input  logic            clk,
    input  logic            reset,

    // ====================
    // Allocation
    // ====================
    input  logic            alloc_enable     [rob_pkg::alloc_lanes],
    input  rob_pkg::tag_t   alloc_tag        [rob_pkg::alloc_lanes],
    input  rob_pkg::dest_t  alloc_dest       [rob_pkg::alloc_lanes],
    output logic            alloc_ok,

    // ====================
    // CDB
    // ====================
    input  logic            cdb_valid        [rob_pkg::cdb_lanes],
    input  rob_pkg::slot_t  cdb_slot         [rob_pkg::cdb_lanes],
    input  rob_pkg::data_t  cdb_data         [rob_pkg::cdb_lanes],
    input  logic            cdb_exception    [rob_pkg::cdb_lanes],

    // Reservation station operand reads
    input  rob_pkg::slot_t  read_slot        [rob_pkg::read_ports],
    output rob_pkg::data_t  read_data        [rob_pkg::read_ports],
    output rob_pkg::tag_t   read_tag         [rob_pkg::read_ports],

    // ====================
    // Commit and status
    // ====================
    output logic            commit_valid     [rob_pkg::commit_lanes],
    output rob_pkg::data_t  commit_data      [rob_pkg::commit_lanes],
    output rob_pkg::dest_t  commit_dest      [rob_pkg::commit_lanes],
    output logic            commit_exception [rob_pkg::commit_lanes],
    output rob_pkg::count_t count,
    output logic            empty,
    output logic            full
);

    rob_alloc_if alloc_bus ();
    rob_cdb_if   cdb_bus ();

    rob_pkg::slot_t      head;
    rob_pkg::count_t     commit_count;
    rob_pkg::rob_entry_t read_entry [rob_pkg::read_ports];
    rob_pkg::rob_entry_t head_entry [rob_pkg::commit_lanes];

    // Pack the plain ports onto the buses
    for (genvar i = 0; i < rob_pkg::alloc_lanes; i++) begin : g_alloc
        assign alloc_bus.enable[i] = alloc_enable[i];
        assign alloc_bus.tag[i]    = alloc_tag[i];
        assign alloc_bus.dest[i]   = alloc_dest[i];
    end

    for (genvar i = 0; i < rob_pkg::cdb_lanes; i++) begin : g_cdb
        assign cdb_bus.valid[i]     = cdb_valid[i];
        assign cdb_bus.slot[i]      = cdb_slot[i];
        assign cdb_bus.data[i]      = cdb_data[i];
        assign cdb_bus.exception[i] = cdb_exception[i];
    end

    assign alloc_ok = alloc_bus.grant;

    rob_pointers u_pointers (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc_bus),
        .commit_count (commit_count),
        .head         (head),
        .count        (count),
        .empty        (empty),
        .full         (full)
    );

    rob_entries u_entries (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc_bus),
        .cdb        (cdb_bus),
        .read_slot  (read_slot),
        .read_entry (read_entry),
        .head       (head),
        .head_entry (head_entry)
    );

    // One forwarding mux per operand port
    for (genvar i = 0; i < rob_pkg::read_ports; i++) begin : g_read
        rob_read_port u_read_port (
            .read_slot (read_slot[i]),
            .stored    (read_entry[i]),
            .cdb       (cdb_bus),
            .alloc     (alloc_bus),
            .read_data (read_data[i]),
            .read_tag  (read_tag[i])
        );
    end

    rob_commit u_commit (
        .head_entry       (head_entry),
        .count            (count),
        .commit_valid     (commit_valid),
        .commit_data      (commit_data),
        .commit_dest      (commit_dest),
        .commit_exception (commit_exception),
        .commit_count     (commit_count)
    );

endmodule

// File: test/rob_checker.sv
`timescale 1ns/1ps

module rob_checker (
    input logic            clk,
    input logic            reset,
    input logic            alloc_ok,
    input logic            commit_valid_0,
    input logic            commit_valid_1,
    input rob_pkg::count_t count,
    input logic            empty
);

    int fail_count = 0;     // Failed assertions so far

    // ====================
    // Pointer rules
    // ====================
    count_bounded: assert property (@(posedge clk) disable iff (!reset)
        count <= rob_pkg::count_t'(rob_pkg::rob_depth))
    else begin
        fail_count++;
        $error("count above buffer depth");
    end

    empty_matches_count: assert property (@(posedge clk) disable iff (!reset)
        empty == (count == '0))
    else begin
        fail_count++;
        $error("empty does not match a zero count");
    end

    // Refused allocation with nothing retiring holds the fill level
    refused_alloc_holds: assert property (@(posedge clk) disable iff (!reset)
        (!alloc_ok && !commit_valid_0) |=> (count == $past(count)))
    else begin
        fail_count++;
        $error("count moved without grant or commit");
    end

    // ====================
    // Commit rules
    // ====================
    commit_in_order: assert property (@(posedge clk) disable iff (!reset)
        commit_valid_1 |-> commit_valid_0)
    else begin
        fail_count++;
        $error("commit lane 1 valid without lane 0");
    end

endmodule

bind rob_top rob_checker rob_checker_i (
    .clk            (clk),
    .reset          (reset),
    .alloc_ok       (alloc_ok),
    .commit_valid_0 (commit_valid[0]),
    .commit_valid_1 (commit_valid[1]),
    .count          (count),
    .empty          (empty)
);

// File: test/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;

    localparam int period        = 100;
    localparam int reset_cycles  = 3;
    localparam int drain_limit   = 8;
    localparam int random_cycles = 160;
    // Reset, reset test 4, fill 8, cdb 3, commit 5 plus drain, alloc 4, random, margin
    localparam int total_cycles  = reset_cycles + 4 + 8 + 3 + 5 + drain_limit + 4
                                   + random_cycles + 40;

    logic            clk;
    logic            reset;
    logic            alloc_enable     [rob_pkg::alloc_lanes];
    rob_pkg::tag_t   alloc_tag        [rob_pkg::alloc_lanes];
    rob_pkg::dest_t  alloc_dest       [rob_pkg::alloc_lanes];
    logic            alloc_ok;
    logic            cdb_valid        [rob_pkg::cdb_lanes];
    rob_pkg::slot_t  cdb_slot         [rob_pkg::cdb_lanes];
    rob_pkg::data_t  cdb_data         [rob_pkg::cdb_lanes];
    logic            cdb_exception    [rob_pkg::cdb_lanes];
    rob_pkg::slot_t  read_slot        [rob_pkg::read_ports];
    rob_pkg::data_t  read_data        [rob_pkg::read_ports];
    rob_pkg::tag_t   read_tag         [rob_pkg::read_ports];
    logic            commit_valid     [rob_pkg::commit_lanes];
    rob_pkg::data_t  commit_data      [rob_pkg::commit_lanes];
    rob_pkg::dest_t  commit_dest      [rob_pkg::commit_lanes];
    logic            commit_exception [rob_pkg::commit_lanes];
    rob_pkg::count_t count;
    logic            empty;
    logic            full;

    // Reference model of the entries and pointers
    rob_pkg::data_t  model_data [rob_pkg::rob_depth];
    rob_pkg::tag_t   model_tag  [rob_pkg::rob_depth];
    rob_pkg::dest_t  model_dest [rob_pkg::rob_depth];
    logic            model_exec [rob_pkg::rob_depth];
    logic            model_exc  [rob_pkg::rob_depth];
    int              model_head = 0;
    int              model_count = 0;

    int    seed = 32'h5ba7_17a8;
    string test_name;
    int    test_errors = 0;
    int    total_errors = 0;
    int    tests_run = 0;
    int    checks = 0;

    rob_top rob_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #(total_cycles * period);
        $display("Watchdog: run did not finish within %0d cycles", total_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic clear_inputs();
        for (int l = 0; l < rob_pkg::alloc_lanes; l++) begin
            alloc_enable[l]  = 1'b0;
            alloc_tag[l]     = '0;
            alloc_dest[l]    = '0;
        end
        for (int l = 0; l < rob_pkg::cdb_lanes; l++) begin
            cdb_valid[l]     = 1'b0;
            cdb_slot[l]      = '0;
            cdb_data[l]      = '0;
            cdb_exception[l] = 1'b0;
        end
        for (int p = 0; p < rob_pkg::read_ports; p++) begin
            read_slot[p]     = '0;
        end
    endtask

    // Tags stay below tag_ready so a pending entry is recognisable
    task automatic set_alloc(input logic e0, input logic e1);
        alloc_enable[0] = e0;
        alloc_enable[1] = e1;
        for (int l = 0; l < rob_pkg::alloc_lanes; l++) begin
            alloc_tag[l]  = rob_pkg::tag_t'(rand_below(7));
            alloc_dest[l] = rob_pkg::dest_t'(rand_below(32));
        end
    endtask

    task automatic set_cdb(input int lane, input rob_pkg::slot_t slot,
                           input rob_pkg::data_t data, input logic exc);
        cdb_valid[lane]     = 1'b1;
        cdb_slot[lane]      = slot;
        cdb_data[lane]      = data;
        cdb_exception[lane] = exc;
    endtask

    // ====================
    // One clock cycle of output checks, then the model update
    // ====================
    task automatic step();
        int             requests;
        int             commits;
        int             rs;
        int             h;
        int             slot_of [rob_pkg::alloc_lanes];
        logic           grant;
        logic           exp_valid [rob_pkg::commit_lanes];
        rob_pkg::data_t exp_data;
        rob_pkg::tag_t  exp_tag;

        #20;    // Past the falling-edge drive
        requests   = int'(alloc_enable[0]) + int'(alloc_enable[1]);
        grant      = (rob_pkg::rob_depth - model_count) >= requests;
        slot_of[0] = (model_head + model_count) % rob_pkg::rob_depth;
        slot_of[1] = (slot_of[0] + int'(alloc_enable[0])) % rob_pkg::rob_depth;
        check_value("alloc_ok", 32'(grant), 32'(alloc_ok));
        check_value("count", model_count, 32'(count));
        check_value("empty", 32'(model_count == 0), 32'(empty));
        check_value("full", 32'(model_count == rob_pkg::rob_depth), 32'(full));

        // Read priority from CDB lane 1 down to the stored entry
        for (int p = 0; p < rob_pkg::read_ports; p++) begin
            rs = int'(read_slot[p]);
            if (cdb_valid[1] && cdb_slot[1] == read_slot[p]) begin
                exp_data = cdb_data[1];
                exp_tag  = rob_pkg::tag_ready;
            end else if (cdb_valid[0] && cdb_slot[0] == read_slot[p]) begin
                exp_data = cdb_data[0];
                exp_tag  = rob_pkg::tag_ready;
            end else if (grant && alloc_enable[1] && slot_of[1] == rs) begin
                exp_data = '0;
                exp_tag  = alloc_tag[1];
            end else if (grant && alloc_enable[0] && slot_of[0] == rs) begin
                exp_data = '0;
                exp_tag  = alloc_tag[0];
            end else begin
                exp_data = model_data[rs];
                exp_tag  = model_tag[rs];
            end
            check_value($sformatf("read_data[%0d]", p), exp_data, read_data[p]);
            check_value($sformatf("read_tag[%0d]", p), 32'(exp_tag), 32'(read_tag[p]));
        end

        // In-order commit over the two oldest entries
        h            = (model_head + 1) % rob_pkg::rob_depth;
        exp_valid[0] = (model_count >= 1) && model_exec[model_head];
        exp_valid[1] = exp_valid[0] && (model_count >= 2) && model_exec[h];
        commits      = 0;
        for (int l = 0; l < rob_pkg::commit_lanes; l++) begin
            h = (model_head + l) % rob_pkg::rob_depth;
            check_value($sformatf("commit_valid[%0d]", l), 32'(exp_valid[l]),
                        32'(commit_valid[l]));
            if (exp_valid[l]) begin
                commits++;
                check_value($sformatf("commit_data[%0d]", l), model_data[h], commit_data[l]);
                check_value($sformatf("commit_dest[%0d]", l), 32'(model_dest[h]),
                            32'(commit_dest[l]));
                check_value($sformatf("commit_exception[%0d]", l), 32'(model_exc[h]),
                            32'(commit_exception[l]));
            end
        end

        @(posedge clk);
        if (grant) begin
            for (int l = 0; l < rob_pkg::alloc_lanes; l++) begin
                if (alloc_enable[l]) begin
                    model_data[slot_of[l]] = '0;
                    model_tag[slot_of[l]]  = alloc_tag[l];
                    model_dest[slot_of[l]] = alloc_dest[l];
                    model_exec[slot_of[l]] = 1'b0;
                    model_exc[slot_of[l]]  = 1'b0;
                end
            end
        end
        for (int l = 0; l < rob_pkg::cdb_lanes; l++) begin    // Lane 1 written last
            if (cdb_valid[l]) begin
                model_data[cdb_slot[l]] = cdb_data[l];
                model_tag[cdb_slot[l]]  = rob_pkg::tag_ready;
                model_exec[cdb_slot[l]] = 1'b1;
                model_exc[cdb_slot[l]]  = cdb_exception[l];
            end
        end
        model_head  = (model_head + commits) % rob_pkg::rob_depth;
        model_count = model_count + (grant ? requests : 0) - commits;
        @(negedge clk);
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        $display("Test %-14s %s, %0d errors", test_name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
        test_errors = 0;
    endtask

    task automatic random_inputs();
        clear_inputs();
        set_alloc(rand_below(4) != 0, rand_below(4) != 0);
        for (int l = 0; l < rob_pkg::cdb_lanes; l++) begin
            if (model_count > 0 && rand_below(4) != 0) begin
                set_cdb(l, rob_pkg::slot_t'((model_head + rand_below(model_count))
                        % rob_pkg::rob_depth), $random(seed), rand_below(8) == 0);
            end
        end
        read_slot[0] = rob_pkg::slot_t'(rand_below(rob_pkg::rob_depth));
        read_slot[1] = rob_pkg::slot_t'(rand_below(rob_pkg::rob_depth));
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        int waited;

        clear_inputs();
        reset = 1'b0;
        for (int i = 0; i < rob_pkg::rob_depth; i++) begin
            model_data[i] = '0;
            model_tag[i]  = '0;
            model_dest[i] = '0;
            model_exec[i] = 1'b0;
            model_exc[i]  = 1'b0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        test_name = "reset";    // Every slot reads back cleared
        for (int k = 0; k < rob_pkg::rob_depth / 2; k++) begin
            read_slot[0] = rob_pkg::slot_t'(2 * k);
            read_slot[1] = rob_pkg::slot_t'(2 * k + 1);
            step();
        end
        end_test();

        test_name = "fill";
        clear_inputs();
        repeat (3) begin
            set_alloc(1'b1, 1'b1);
            step();
        end
        set_alloc(1'b1, 1'b0);
        step();
        set_alloc(1'b1, 1'b1);  // One entry free, two asked
        step();
        set_alloc(1'b0, 1'b1);
        step();
        set_alloc(1'b1, 1'b0);  // Full
        step();
        clear_inputs();
        step();
        end_test();

        test_name = "cdb_forward";
        set_cdb(0, 3'd3, 32'h1111_0003, 1'b0);
        set_cdb(1, 3'd3, 32'h2222_0003, 1'b1);
        read_slot[0] = 3'd3;
        read_slot[1] = 3'd3;
        step();
        clear_inputs();
        set_cdb(0, 3'd5, 32'h1111_0005, 1'b0);
        read_slot[0] = 3'd3;
        read_slot[1] = 3'd5;
        step();
        clear_inputs();
        read_slot[0] = 3'd3;
        read_slot[1] = 3'd5;
        step();
        end_test();

        test_name = "commit";   // Head still pending, younger results first
        set_cdb(0, 3'd2, $random(seed), 1'b0);
        set_cdb(1, 3'd1, $random(seed), 1'b0);
        step();
        clear_inputs();
        step();
        set_cdb(0, 3'd0, $random(seed), 1'b1);
        step();
        clear_inputs();
        set_cdb(0, 3'd4, $random(seed), 1'b0);
        set_cdb(1, 3'd6, $random(seed), 1'b1);
        step();
        clear_inputs();
        set_cdb(0, 3'd7, $random(seed), 1'b0);
        step();
        clear_inputs();
        waited = 0;
        while (count != '0 && waited < drain_limit) begin
            step();
            waited++;
        end
        if (count != '0) begin
            $display("Test %s: buffer did not drain after all results arrived", test_name);
            test_errors++;
        end
        end_test();

        test_name = "alloc_forward";
        set_alloc(1'b1, 1'b1);
        read_slot[0] = 3'd0;
        read_slot[1] = 3'd1;
        step();
        alloc_enable[0] = 1'b0;
        alloc_enable[1] = 1'b0;
        step();
        set_alloc(1'b0, 1'b1);  // Lane 1 alone lands on the tail
        read_slot[0] = 3'd2;
        step();
        alloc_enable[1] = 1'b0;
        step();
        end_test();

        test_name = "random";
        for (int c = 0; c < random_cycles; c++) begin
            random_inputs();
            step();
        end
        clear_inputs();
        end_test();

        $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, checks, total_errors, rob_top_i.rob_checker_i.fail_count);
        if (total_errors == 0 && rob_top_i.rob_checker_i.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
